//--- isa_pkg.sv
package isa_pkg;

  // core widths
  localparam int word_w      = 16;  // data word, operand, logical address
  localparam int op_w        = 8;   // opcode field, high byte of first word
  localparam int reg_field_w = 8;   // register field, low byte of first word

  // register file
  localparam int reg_count = 8;
  localparam int reg_idx_w = 3;     // low bits of the register field

  // pc value after reset
  localparam int program_start = 46;

  // instruction set, each instruction is an opcode word plus an operand word
  // codes not listed here retire without effect
  typedef enum logic [op_w-1:0] {
    op_jmp       = 8'd1,  // operand is the new pc
    op_ram2reg   = 8'd2,  // reg = mem[operand]
    op_reg2ram   = 8'd3,  // mem[operand] = reg
    op_num2reg   = 8'd4,  // reg = operand
    op_reg_plus  = 8'd5,  // reg += operand
    op_reg_minus = 8'd6   // reg -= operand
  } opcode_t;

endpackage

//--- mmu_pkg.sv
package mmu_pkg;

  localparam int page_size   = 72;  // words per segment
  localparam int seg_count   = 14;  // segments inside 1024 words
  localparam int seg_w       = 4;
  localparam int phys_addr_w = 10;

  // 65535 / 72 gives at most 910, stored as page + 1
  localparam int lpage_w  = 10;
  localparam int offset_w = 7;      // offset below page_size

  // page walker states
  typedef enum logic [2:0] {
    idle,        // wait for fetch or data request
    check_last,  // compare with last translated page
    walk,        // follow segment chain, one segment per cycle
    alloc,       // scan for lowest free segment
    access,      // drive memory port
    wait_read    // read data returns
  } walk_state_t;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
  input  logic                              clka,
  input  logic                              rst,
  input  logic                              busy,
  input  logic                              xlat_done,
  input  logic [isa_pkg::word_w-1:0]        rdata,
  input  logic                              fault,
  output logic                              fetch_req,
  output logic [isa_pkg::word_w-1:0]        fetch_addr,
  output logic                              inst_valid,
  output isa_pkg::opcode_t                  inst_op,
  output logic [isa_pkg::reg_field_w-1:0]   inst_reg,
  output logic [isa_pkg::word_w-1:0]        inst_operand
);

  typedef enum logic [1:0] {
    f_issue,     // wait for execute to go idle
    f_op_wait,   // opcode word outstanding
    f_arg_wait   // operand word outstanding
  } fetch_state_t;

  fetch_state_t state;
  logic [isa_pkg::word_w-1:0] pc;

  assign fetch_addr = pc;  // held while a read is outstanding

  always_ff @(posedge clka) begin
    if (!rst) begin
      state      <= f_issue;
      pc         <= isa_pkg::word_w'(isa_pkg::program_start);
      fetch_req  <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      fetch_req  <= 1'b0;  // both are single-cycle pulses
      inst_valid <= 1'b0;
      case (state)
        f_issue: begin
          if (!busy && !fault) begin
            fetch_req <= 1'b1;
            state     <= f_op_wait;
          end
        end
        f_op_wait: begin
          if (xlat_done) begin
            inst_op   <= isa_pkg::opcode_t'(rdata[isa_pkg::word_w-1 -: isa_pkg::op_w]);
            inst_reg  <= rdata[isa_pkg::reg_field_w-1:0];
            pc        <= pc + 1'b1;
            fetch_req <= 1'b1;  // operand read right away
            state     <= f_arg_wait;
          end
        end
        f_arg_wait: begin
          if (xlat_done) begin
            if (inst_op == isa_pkg::op_jmp) begin
              pc <= rdata;  // jump stays local
            end else begin
              inst_operand <= rdata;
              pc           <= pc + 1'b1;
              inst_valid   <= 1'b1;
            end
            state <= f_issue;
          end
        end
        default: state <= f_issue;
      endcase
    end
  end

  // a fetch must be answered before the next one goes out
  a_fetch_outstanding: assert property (
    @(posedge clka) disable iff (!rst)
    fetch_req |=> (!fetch_req until xlat_done)
  ) else $error("fetch_req raised while a fetch is outstanding");

endmodule

//--- execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
  input  logic                              clka,
  input  logic                              rst,
  input  logic                              inst_valid,
  input  isa_pkg::opcode_t                  inst_op,
  input  logic [isa_pkg::reg_field_w-1:0]   inst_reg,
  input  logic [isa_pkg::word_w-1:0]        inst_operand,
  input  logic                              xlat_done,
  input  logic [isa_pkg::word_w-1:0]        rdata,
  output logic                              busy,
  output logic                              data_req,
  output logic [isa_pkg::word_w-1:0]        data_addr,
  output logic                              data_we,
  output logic [isa_pkg::word_w-1:0]        data_wdata
);

  typedef enum logic {
    ex_idle,  // ready for next instruction
    ex_mem    // load or store in flight
  } exec_state_t;

  exec_state_t state;

  logic [isa_pkg::word_w-1:0]    regs [isa_pkg::reg_count];
  logic [isa_pkg::reg_idx_w-1:0] rd;      // register of incoming instruction
  logic [isa_pkg::reg_idx_w-1:0] ld_reg;  // load target while waiting

  assign rd = inst_reg[isa_pkg::reg_idx_w-1:0];  // upper bits ignored

  // high in the issue cycle, stays up only for memory ops
  assign busy = inst_valid || (state == ex_mem);

  always_ff @(posedge clka) begin
    if (!rst) begin
      state    <= ex_idle;
      data_req <= 1'b0;
      data_we  <= 1'b0;
      for (int i = 0; i < isa_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      data_req <= 1'b0;  // one-cycle request pulse
      case (state)
        ex_idle: begin
          if (inst_valid) begin
            case (inst_op)
              isa_pkg::op_num2reg:   regs[rd] <= inst_operand;
              isa_pkg::op_reg_plus:  regs[rd] <= regs[rd] + inst_operand;  // wraps mod 2^16
              isa_pkg::op_reg_minus: regs[rd] <= regs[rd] - inst_operand;
              isa_pkg::op_ram2reg: begin
                data_req  <= 1'b1;
                data_addr <= inst_operand;
                data_we   <= 1'b0;
                ld_reg    <= rd;
                state     <= ex_mem;
              end
              isa_pkg::op_reg2ram: begin
                data_req   <= 1'b1;
                data_addr  <= inst_operand;
                data_we    <= 1'b1;
                data_wdata <= regs[rd];
                state      <= ex_mem;
              end
              default: ;  // unknown codes retire as no-ops
            endcase
          end
        end
        ex_mem: begin
          if (xlat_done) begin
            if (!data_we) begin
              regs[ld_reg] <= rdata;  // load data valid with done
            end
            state <= ex_idle;
          end
        end
        default: state <= ex_idle;
      endcase
    end
  end

  // fetch has to wait for retirement before presenting the next one
  a_no_issue_when_busy: assert property (
    @(posedge clka) disable iff (!rst)
    inst_valid |-> (state == ex_idle)
  ) else $error("instruction issued while a memory op is in flight");

endmodule

//--- page_walker.sv
`timescale 1ns/1ns

module page_walker (
  input  logic                              clka,
  input  logic                              rst,
  input  logic                              fetch_req,
  input  logic [isa_pkg::word_w-1:0]        fetch_addr,
  input  logic                              data_req,
  input  logic [isa_pkg::word_w-1:0]        data_addr,
  input  logic                              data_we,
  input  logic [isa_pkg::word_w-1:0]        data_wdata,
  output logic                              xlat_done,
  output logic [isa_pkg::word_w-1:0]        rdata,
  output logic                              fault,
  output logic                              mem_en,
  output logic                              mem_we,
  output logic [mmu_pkg::phys_addr_w-1:0]   mem_addr,
  output logic [isa_pkg::word_w-1:0]        mem_wdata,
  input  logic [isa_pkg::word_w-1:0]        mem_rdata
);

  localparam logic [mmu_pkg::seg_w-1:0] last_scan = mmu_pkg::seg_w'(mmu_pkg::seg_count - 1);

  mmu_pkg::walk_state_t state;

  logic [mmu_pkg::seg_w-1:0]   chain_tab [mmu_pkg::seg_count];  // next segment, 0 ends chain
  logic [mmu_pkg::lpage_w-1:0] page_tab  [mmu_pkg::seg_count];  // page + 1, 0 when free

  logic [isa_pkg::word_w-1:0]   req_addr;
  logic [mmu_pkg::lpage_w-1:0]  req_page;
  logic [mmu_pkg::offset_w-1:0] req_offset;
  logic [mmu_pkg::lpage_w-1:0]  page_q;
  logic [mmu_pkg::lpage_w-1:0]  page_tag;
  logic [mmu_pkg::offset_w-1:0] offset_q;
  logic                         we_q;
  logic [isa_pkg::word_w-1:0]   wdata_q;
  logic [mmu_pkg::seg_w-1:0]    seg_q;      // walk pointer, then target segment
  logic [mmu_pkg::seg_w-1:0]    tail_q;     // chain end found by the walk
  logic [mmu_pkg::seg_w-1:0]    scan_q;     // free segment search
  logic [mmu_pkg::lpage_w-1:0]  last_page;
  logic [mmu_pkg::seg_w-1:0]    last_seg;
  logic                         wr_done;

  // only one requester is active at a time
  assign req_addr   = fetch_req ? fetch_addr : data_addr;
  assign req_page   = mmu_pkg::lpage_w'(req_addr / mmu_pkg::page_size);
  assign req_offset = mmu_pkg::offset_w'(req_addr % mmu_pkg::page_size);
  assign page_tag   = page_q + 1'b1;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state     <= mmu_pkg::idle;
      fault     <= 1'b0;
      wr_done   <= 1'b0;
      last_page <= '0;  // segment 0 already holds page 0
      last_seg  <= '0;
      for (int i = 0; i < mmu_pkg::seg_count; i++) begin
        chain_tab[i] <= '0;
        page_tab[i]  <= '0;
      end
      page_tab[0] <= mmu_pkg::lpage_w'(1);
    end else begin
      wr_done <= 1'b0;
      case (state)
        mmu_pkg::idle: begin
          if ((fetch_req || data_req) && !fault) begin  // halted once faulted
            page_q   <= req_page;
            offset_q <= req_offset;
            we_q     <= data_req && data_we;
            wdata_q  <= data_wdata;
            state    <= mmu_pkg::check_last;
          end
        end
        mmu_pkg::check_last: begin
          if (page_q == last_page) begin
            seg_q <= last_seg;  // repeat page, no walk
            state <= mmu_pkg::access;
          end else begin
            seg_q <= '0;        // chain starts at segment 0
            state <= mmu_pkg::walk;
          end
        end
        mmu_pkg::walk: begin
          if (page_tab[seg_q] == page_tag) begin
            state <= mmu_pkg::access;
          end else if (chain_tab[seg_q] == '0) begin
            tail_q <= seg_q;
            scan_q <= mmu_pkg::seg_w'(1);  // segment 0 is never free
            state  <= mmu_pkg::alloc;
          end else begin
            seg_q <= chain_tab[seg_q];
          end
        end
        mmu_pkg::alloc: begin
          if (page_tab[scan_q] == '0) begin
            page_tab[scan_q]  <= page_tag;
            chain_tab[tail_q] <= scan_q;  // link new segment at chain end
            seg_q             <= scan_q;
            state             <= mmu_pkg::access;
          end else if (scan_q == last_scan) begin
            fault <= 1'b1;  // out of segments, never answered
            state <= mmu_pkg::idle;
          end else begin
            scan_q <= scan_q + 1'b1;
          end
        end
        mmu_pkg::access: begin
          last_page <= page_q;
          last_seg  <= seg_q;
          if (we_q) begin
            wr_done <= 1'b1;
            state   <= mmu_pkg::idle;
          end else begin
            state <= mmu_pkg::wait_read;
          end
        end
        mmu_pkg::wait_read: state <= mmu_pkg::idle;
        default:            state <= mmu_pkg::idle;
      endcase
    end
  end

  assign mem_en    = (state == mmu_pkg::access);
  assign mem_we    = mem_en && we_q;
  assign mem_addr  = mmu_pkg::phys_addr_w'(seg_q * mmu_pkg::page_size + offset_q);
  assign mem_wdata = wdata_q;
  assign rdata     = mem_rdata;  // valid in the data cycle
  assign xlat_done = wr_done || (state == mmu_pkg::wait_read);

  a_one_requester: assert property (
    @(posedge clka) disable iff (!rst)
    !(fetch_req && data_req)
  ) else $error("fetch and data request in the same cycle");

  // a write goes out with the enable and is answered on the next cycle
  a_write_done: assert property (
    @(posedge clka) disable iff (!rst)
    mem_we |-> mem_en ##1 xlat_done
  ) else $error("memory write without enable or without done");

endmodule

//--- cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
  input  logic                              clka,
  input  logic                              rst,
  output logic                              mem_en,
  output logic                              mem_we,
  output logic [mmu_pkg::phys_addr_w-1:0]   mem_addr,
  output logic [isa_pkg::word_w-1:0]        mem_wdata,
  input  logic [isa_pkg::word_w-1:0]        mem_rdata,
  output logic                              fault
);

  // fetch and execute requests into the walker
  logic                            fetch_req;
  logic [isa_pkg::word_w-1:0]      fetch_addr;
  logic                            data_req;
  logic [isa_pkg::word_w-1:0]      data_addr;
  logic                            data_we;
  logic [isa_pkg::word_w-1:0]      data_wdata;

  // shared answer path
  logic                            xlat_done;
  logic [isa_pkg::word_w-1:0]      rdata;

  // fetch to execute
  logic                            busy;
  logic                            inst_valid;
  isa_pkg::opcode_t                inst_op;
  logic [isa_pkg::reg_field_w-1:0] inst_reg;
  logic [isa_pkg::word_w-1:0]      inst_operand;

  fetch_stage u_fetch_stage (.*);

  execute_stage u_execute_stage (.*);

  page_walker u_page_walker (.*);

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clka
);

  localparam int half_period = 50;  // 100 ns period

  initial begin
    clka = 1'b0;
    forever begin
      #half_period clka = ~clka;
    end
  end

endmodule

//--- tb_memory.sv
`timescale 1ns/1ns

module tb_memory (
  input  logic                              clka,
  input  logic                              en,
  input  logic                              we,
  input  logic [mmu_pkg::phys_addr_w-1:0]   addr,
  input  logic [isa_pkg::word_w-1:0]        wdata,
  output logic [isa_pkg::word_w-1:0]        rdata
);

  localparam int depth = 1 << mmu_pkg::phys_addr_w;  // 1024 words

  logic [isa_pkg::word_w-1:0] mem [depth];

  // untouched words read back a tag of their own address
  initial begin
    rdata = '0;  // known read port before the first access
    for (int a = 0; a < depth; a++) begin
      mem[a] = {6'h2d, 10'(a)};
    end
  end

  // single port, read data valid one cycle after en
  always @(posedge clka) begin
    if (en) begin
      if (we) begin
        mem[addr] = wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu;

  localparam int reset_cycles     = 10;
  localparam int cycles_per_instr = 60;
  localparam int wrap_at   = mmu_pkg::page_size - 2;  // last slot of page 0
  localparam int data_base = 40;                      // data words below the program

  logic                            clka;
  logic                            rst;
  logic                            mem_en;
  logic                            mem_we;
  logic [mmu_pkg::phys_addr_w-1:0] mem_addr;
  logic [isa_pkg::word_w-1:0]      mem_wdata;
  logic [isa_pkg::word_w-1:0]      mem_rdata;
  logic                            fault;

  logic [15:0]                     lfsr = 16'd41433;
  int                              pc;
  int                              n_instr;
  int                              seg_page [mmu_pkg::seg_count];  // -1 when free
  logic [isa_pkg::word_w-1:0]      regs_m [isa_pkg::reg_count];

  logic [mmu_pkg::phys_addr_w-1:0] exp_addr [32];
  logic [isa_pkg::word_w-1:0]      exp_data [32];
  int                              exp_test [32];
  int                              last_of [7];  // last expected store per test
  int                              exp_count;
  int                              head;
  logic [mmu_pkg::phys_addr_w-1:0] skip_addr;
  logic                            seen_first;
  int                              test_err [7];
  int                              n_pass;
  int                              n_fail;
  int                              cycles;
  int                              limit = 1000000;

  tb_clock u_tb_clock (.clka);

  tb_memory u_memory (
    .clka,
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  cpu_core u_cpu_core (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
    lfsr = {fb, lfsr[15:1]};
    return fb;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[14:0], lfsr_step()};
    end
    return v;
  endfunction

  // chain lookup, then lowest free segment, -1 when none is left
  function automatic int translate(input int laddr);
    int page;
    int offset;
    page   = laddr / mmu_pkg::page_size;
    offset = laddr % mmu_pkg::page_size;
    for (int s = 0; s < mmu_pkg::seg_count; s++) begin
      if (seg_page[s] == page) begin
        return s * mmu_pkg::page_size + offset;
      end
    end
    for (int s = 1; s < mmu_pkg::seg_count; s++) begin
      if (seg_page[s] < 0) begin
        seg_page[s] = page;
        return s * mmu_pkg::page_size + offset;
      end
    end
    return -1;
  endfunction

  function automatic int current_test();
    if (!seen_first) begin
      return 1;
    end
    return (head < exp_count) ? exp_test[head] : 6;
  endfunction

  task automatic emit(input isa_pkg::opcode_t op, input int r, input int operand);
    if (pc == wrap_at) begin  // page 0 full, continue at 0
      u_memory.mem[pc]     = {isa_pkg::op_jmp, 8'd0};
      u_memory.mem[pc + 1] = 16'd0;
      pc = 0;
      n_instr++;
    end
    u_memory.mem[pc]     = {op, 8'(r)};
    u_memory.mem[pc + 1] = 16'(operand);
    pc += 2;
    n_instr++;
  endtask

  task automatic alu(input isa_pkg::opcode_t op, input int r, input logic [15:0] v);
    emit(op, r, int'(v));
    case (op)
      isa_pkg::op_num2reg:  regs_m[r] = v;
      isa_pkg::op_reg_plus: regs_m[r] = regs_m[r] + v;
      default:              regs_m[r] = regs_m[r] - v;
    endcase
  endtask

  task automatic store(input int t, input int r, input int laddr);
    int phys;
    emit(isa_pkg::op_reg2ram, r, laddr);
    phys = translate(laddr);
    if (phys >= 0) begin
      exp_addr[exp_count] = mmu_pkg::phys_addr_w'(phys);
      exp_data[exp_count] = regs_m[r];
      exp_test[exp_count] = t;
      last_of[t]          = exp_count;
      exp_count++;
    end
  endtask

  task automatic build_program();
    int          jmp_slot;
    int          free_segs;
    logic [15:0] v;
    seg_page[0] = 0;  // page 0 lives in segment 0
    for (int s = 1; s < mmu_pkg::seg_count; s++) begin
      seg_page[s] = -1;
    end
    pc = isa_pkg::program_start;
    alu(isa_pkg::op_num2reg, 1, rand_bits(16));
    store(2, 1, data_base + 1);
    alu(isa_pkg::op_num2reg, 2, rand_bits(16));
    alu(isa_pkg::op_reg_plus, 2, rand_bits(16));
    store(3, 2, data_base + 2);
    alu(isa_pkg::op_reg_minus, 2, rand_bits(16));
    store(3, 2, data_base + 3);
    v = rand_bits(16);
    u_memory.mem[data_base] = v;  // word for the load
    emit(isa_pkg::op_ram2reg, 3, data_base);
    regs_m[3] = v;
    emit(isa_pkg::op_jmp, 0, 0);
    jmp_slot = pc - 1;
    emit(isa_pkg::op_reg2ram, 3, data_base + 5);  // jumped over
    skip_addr = mmu_pkg::phys_addr_w'(data_base + 5);
    u_memory.mem[jmp_slot] = 16'(pc);
    store(4, 3, data_base + 4);
    alu(isa_pkg::op_num2reg, 4, rand_bits(16));
    store(5, 4, 3 * mmu_pkg::page_size + int'(rand_bits(6)));
    alu(isa_pkg::op_reg_plus, 4, rand_bits(16));
    store(5, 4, 1 * mmu_pkg::page_size + int'(rand_bits(6)));
    store(5, 4, 3 * mmu_pkg::page_size + int'(rand_bits(6)));
    free_segs = 0;
    for (int s = 0; s < mmu_pkg::seg_count; s++) begin
      if (seg_page[s] < 0) begin
        free_segs++;
      end
    end
    alu(isa_pkg::op_num2reg, 5, rand_bits(16));
    for (int p = 0; p <= free_segs; p++) begin  // one page too many
      store(6, 5, (5 + p) * mmu_pkg::page_size + int'(rand_bits(6)));
    end
  endtask

  task automatic report(input int t, input string name);
    $display("test %0d %s: %s", t, name, (test_err[t] == 0) ? "ok" : "FAILED");
    if (test_err[t] == 0) begin
      n_pass++;
    end else begin
      n_fail++;
    end
  endtask

  always @(posedge clka) begin
    if (!rst) begin
      head       <= 0;
      seen_first <= 1'b0;
    end else begin
      if (mem_en) begin
        seen_first <= 1'b1;
      end
      if (mem_we && head < exp_count) begin
        head <= head + 1;  // one expected store consumed
      end
    end
  end

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // checks sampled mid-cycle, away from the DUT edge
  a_first_read: assert property (@(negedge clka) disable iff (!rst)
    (mem_en && !seen_first) |-> (!mem_we && mem_addr == 10'(isa_pkg::program_start)))
  else begin
    test_err[1]++;
    $display("MISMATCH at %0t: first access at %0d we %b, expected a read at %0d",
             $time, mem_addr, mem_we, isa_pkg::program_start);
  end

  a_store: assert property (@(negedge clka) disable iff (!rst)
    mem_we |-> (head < exp_count && mem_addr == exp_addr[head]
                && mem_wdata == exp_data[head]))
  else begin
    test_err[current_test()]++;
    $display("MISMATCH at %0t: store %h to %0d, expected %h to %0d",
             $time, mem_wdata, mem_addr, exp_data[head], exp_addr[head]);
  end

  a_jump_skip: assert property (@(negedge clka) disable iff (!rst)
    mem_we |-> (mem_addr != skip_addr))
  else begin
    test_err[4]++;
    $display("the store placed after the jump was executed at %0t", $time);
  end

  a_fault_late: assert property (@(negedge clka) disable iff (!rst)
    fault |-> (head == exp_count))
  else begin
    test_err[current_test()]++;
    $display("fault raised at %0t with %0d expected stores missing", $time, exp_count - head);
  end

  a_halt: assert property (@(negedge clka) disable iff (!rst)
    fault |-> !mem_we)
  else begin
    test_err[6]++;
    $display("a store went out after the fault at %0t", $time);
  end

  initial begin
    int total_err;
    rst = 1'b0;
    @(negedge clka);
    build_program();
    limit = n_instr * cycles_per_instr + reset_cycles;
    repeat (reset_cycles - 1) @(negedge clka);
    rst = 1'b1;
    wait (seen_first);
    report(1, "reset and first fetch");
    wait (head > last_of[2]);
    report(2, "number to register and store");
    wait (head > last_of[3]);
    report(3, "plus and minus");
    wait (head > last_of[4]);
    report(4, "load copy and jump");
    wait (head > last_of[5]);
    report(5, "page allocation and reuse");
    wait (fault);
    repeat (20) @(negedge clka);  // core must stay halted
    report(6, "out of segments");
    total_err = 0;
    for (int t = 1; t <= 6; t++) begin
      total_err += test_err[t];
    end
    $display("tests passed %0d failed %0d, failed checks %0d", n_pass, n_fail, total_err);
    if (n_fail == 0 && total_err == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
isa_pkg.sv
mmu_pkg.sv
fetch_stage.sv
execute_stage.sv
page_walker.sv
cpu_core.sv
tb_clock.sv
tb_memory.sv
tb_cpu.sv

//--- Makefile
# Verilator build for the cpu_core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
RTL_TOP   ?= cpu_core
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
